//--- hw/sqrt_pkg.sv
package sqrt_pkg;

    // **************************************************
    // datapath widths
    // **************************************************
    localparam int DATA_WIDTH  = 32;
    localparam int FRAC_WIDTH  = 16;
    localparam int TAG_WIDTH   = 4;

    // remainder needs two guard bits over the data.
    localparam int ACC_WIDTH   = DATA_WIDTH + 2;
    // radicand plus the appended fraction zeros.
    localparam int SHIFT_WIDTH = DATA_WIDTH + FRAC_WIDTH;

    // **************************************************
    // request queue
    // **************************************************
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int DROP_WIDTH     = 8;

    // **************************************************
    // core iteration counts
    // **************************************************
    localparam int ITER_CNT_WIDTH = 5;

    localparam logic [ITER_CNT_WIDTH-1:0] ITER_INT =
        ITER_CNT_WIDTH'(DATA_WIDTH / 2);
    localparam logic [ITER_CNT_WIDTH-1:0] ITER_FIXED =
        ITER_CNT_WIDTH'((DATA_WIDTH + FRAC_WIDTH) / 2);

    typedef enum logic {
        MODE_INT   = 1'b0,  // plain unsigned integer.
        MODE_FIXED = 1'b1   // unsigned 16.16.
    } sqrt_mode_e;

    typedef enum logic {
        DISP_IDLE = 1'b0,
        DISP_BUSY = 1'b1
    } disp_state_e;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        sqrt_mode_e            mode;
        logic [DATA_WIDTH-1:0] radicand;
    } sqrt_req_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        sqrt_mode_e            mode;
        logic [DATA_WIDTH-1:0] root;
    } sqrt_resp_t;

endpackage

//--- hw/sqrt_req_fifo.sv
`timescale 1ns/1ps

module sqrt_req_fifo (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              push,
    input  sqrt_pkg::sqrt_req_t               push_data,
    input  logic                              pop,
    output sqrt_pkg::sqrt_req_t               head,
    output logic                              empty,
    output logic                              full,
    output logic [sqrt_pkg::DROP_WIDTH-1:0]   drop_count
);
    import sqrt_pkg::*;

    sqrt_req_t                 mem [0:FIFO_DEPTH-1];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   count;
    logic                      push_ok;
    logic                      push_drop;

    // **************************************************
    // status
    // **************************************************
    assign empty     = (count == '0);
    assign full      = (count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign push_ok   = push && !full;
    assign push_drop = push && full;

    // fall-through read port.
    assign head = mem[rd_ptr];

    // **************************************************
    // storage and pointers
    // **************************************************
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two.
        end
    end

    // pop is only raised with a valid head.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together.
            endcase
        end
    end

    // **************************************************
    // drop counter
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_count <= '0;
        end else if (push_drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;  // saturates at all ones.
        end
    end

endmodule

//--- hw/fp_sqrt.sv
`timescale 1ns/1ps

module fp_sqrt (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              go,
    input  sqrt_pkg::sqrt_mode_e              mode,
    input  logic [sqrt_pkg::DATA_WIDTH-1:0]   radicand,
    output logic [sqrt_pkg::DATA_WIDTH-1:0]   root,
    output logic                              done
);
    import sqrt_pkg::*;

    // control.
    logic                      running;
    logic                      start;
    logic                      last;
    logic [ITER_CNT_WIDTH-1:0] iter_cnt;
    logic [ITER_CNT_WIDTH-1:0] iter_limit;

    // datapath.
    logic [SHIFT_WIDTH-1:0]    x;
    logic [SHIFT_WIDTH-1:0]    x_next;
    logic [ACC_WIDTH-1:0]      acc;
    logic [ACC_WIDTH-1:0]      acc_next;
    logic [ACC_WIDTH-1:0]      acc_shift;
    logic [ACC_WIDTH-1:0]      trial;
    logic [DATA_WIDTH-1:0]     quotient;
    logic [DATA_WIDTH-1:0]     quotient_next;

    // a go during an operation is ignored.
    assign start = go && !running;

    // all iterations have run, result is in quotient.
    assign last = running && (iter_cnt == iter_limit);

    // **************************************************
    // sequencing
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            running  <= 1'b0;
            iter_cnt <= '0;
        end else if (start) begin
            running  <= 1'b1;
            iter_cnt <= '0;
        end else if (last) begin
            running  <= 1'b0;
        end else if (running) begin
            iter_cnt <= iter_cnt + 1'b1;
        end
    end

    // fixed mode needs eight more bit pairs for the fraction.
    always_ff @(posedge clk) begin
        if (start) begin
            iter_limit <= (mode == MODE_FIXED) ? ITER_FIXED : ITER_INT;
        end
    end

    // **************************************************
    // one restoring step per cycle
    // **************************************************
    always_comb begin
        // bring down the next two radicand bits.
        acc_shift = {acc[ACC_WIDTH-3:0], x[SHIFT_WIDTH-1 -: 2]};
        trial     = acc_shift - {quotient, 2'b01};
        x_next    = {x[SHIFT_WIDTH-3:0], 2'b00};

        if (trial[ACC_WIDTH-1]) begin
            // trial went negative, keep remainder.
            acc_next      = acc_shift;
            quotient_next = {quotient[DATA_WIDTH-2:0], 1'b0};
        end else begin
            acc_next      = trial;
            quotient_next = {quotient[DATA_WIDTH-2:0], 1'b1};
        end
    end

    // integer mode stops after the top DATA_WIDTH bits of x.
    always_ff @(posedge clk) begin
        if (start) begin
            acc      <= '0;
            x        <= {radicand, {FRAC_WIDTH{1'b0}}};
            quotient <= '0;
        end else if (running && !last) begin
            acc      <= acc_next;
            x        <= x_next;
            quotient <= quotient_next;
        end
    end

    // **************************************************
    // result
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= last;  // single cycle, running drops with it.
        end
    end

    always_ff @(posedge clk) begin
        if (last) begin
            root <= quotient;
        end
    end

endmodule

//--- hw/sqrt_dispatch.sv
`timescale 1ns/1ps

module sqrt_dispatch (
    input  logic                              clk,
    input  logic                              reset,
    input  sqrt_pkg::sqrt_req_t               head,
    input  logic                              empty,
    output logic                              pop,
    output logic                              go,
    output sqrt_pkg::sqrt_mode_e              core_mode,
    output logic [sqrt_pkg::DATA_WIDTH-1:0]   core_radicand,
    input  logic [sqrt_pkg::DATA_WIDTH-1:0]   core_root,
    input  logic                              core_done,
    output logic                              resp_valid,
    output sqrt_pkg::sqrt_resp_t              resp,
    output logic                              busy
);
    import sqrt_pkg::*;

    disp_state_e          state;
    logic [TAG_WIDTH-1:0] tag_q;
    sqrt_mode_e           mode_q;
    logic                 launch;
    logic                 finish;

    // **************************************************
    // launch path
    // **************************************************
    assign launch = (state == DISP_IDLE) && !empty;
    assign finish = (state == DISP_BUSY) && core_done;

    // pop and go share the launch cycle.
    assign pop           = launch;
    assign go            = launch;
    assign core_mode     = head.mode;
    assign core_radicand = head.radicand;

    assign busy = (state == DISP_BUSY);

    // **************************************************
    // state machine
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DISP_IDLE;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (launch) begin
                        state <= DISP_BUSY;
                    end
                end
                DISP_BUSY: begin
                    if (finish) begin
                        state <= DISP_IDLE;  // idle again as resp_valid rises.
                    end
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

    // request in flight.
    always_ff @(posedge clk) begin
        if (launch) begin
            tag_q  <= head.tag;
            mode_q <= head.mode;
        end
    end

    // **************************************************
    // response
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= finish;
        end
    end

    // held until the next response.
    always_ff @(posedge clk) begin
        if (finish) begin
            resp.tag  <= tag_q;
            resp.mode <= mode_q;
            resp.root <= core_root;
        end
    end

endmodule

//--- hw/sqrt_engine.sv
`timescale 1ns/1ps

module sqrt_engine (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              req_push,
    input  sqrt_pkg::sqrt_req_t               req,
    output logic                              resp_valid,
    output sqrt_pkg::sqrt_resp_t              resp,
    output logic                              full,
    output logic                              empty,
    output logic                              busy,
    output logic [sqrt_pkg::DROP_WIDTH-1:0]   drop_count
);
    import sqrt_pkg::*;

    sqrt_req_t             head;
    logic                  pop;
    logic                  go;
    sqrt_mode_e            core_mode;
    logic [DATA_WIDTH-1:0] core_radicand;
    logic [DATA_WIDTH-1:0] core_root;
    logic                  core_done;

    // **************************************************
    // request queue
    // **************************************************
    sqrt_req_fifo fifo0 (
        .clk        (clk),
        .reset      (reset),
        .push       (req_push),
        .push_data  (req),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .full       (full),
        .drop_count (drop_count)
    );

    // **************************************************
    // dispatcher and core
    // **************************************************
    sqrt_dispatch disp0 (
        .clk           (clk),
        .reset         (reset),
        .head          (head),
        .empty         (empty),
        .pop           (pop),
        .go            (go),
        .core_mode     (core_mode),
        .core_radicand (core_radicand),
        .core_root     (core_root),
        .core_done     (core_done),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .busy          (busy)
    );

    fp_sqrt core0 (
        .clk      (clk),
        .reset    (reset),
        .go       (go),
        .mode     (core_mode),
        .radicand (core_radicand),
        .root     (core_root),
        .done     (core_done)
    );

endmodule

//--- dv/sqrt_model.svh
`ifndef SQRT_MODEL_SVH
`define SQRT_MODEL_SVH

// **************************************************
// random numbers
// **************************************************

// 32-bit xorshift with shifts 13, 17 and 5.
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// spread radicands over small, middle and full ranges.
function automatic logic [31:0] shape_radicand(
    input logic [31:0] r,
    input logic [1:0]  sel
);
    logic [31:0] shaped;
    case (sel)
        2'd0:    shaped = r >> 24;  // tiny values.
        2'd1:    shaped = r >> 12;
        2'd2:    shaped = r | 32'hff00_0000;  // close to the top.
        default: shaped = r;
    endcase
    return shaped;
endfunction

// **************************************************
// reference root
// **************************************************

// largest r with r*r not above n, one bit at a time.
// fixed mode scales the radicand by 2**16 first.
function automatic logic [31:0] ref_root(
    input logic        fixed,
    input logic [31:0] radicand
);
    logic [63:0] n;
    logic [63:0] r;
    logic [63:0] trial;
    if (fixed) begin
        n = {16'h0000, radicand, 16'h0000};
    end else begin
        n = {32'h0000_0000, radicand};
    end
    r = '0;
    for (int b = 31; b >= 0; b--) begin
        trial = r | (64'd1 << b);
        if (trial * trial <= n) begin
            r = trial;
        end
    end
    return r[31:0];
endfunction

`endif

//--- dv/tb_sqrt_engine.sv
`timescale 1ns/1ps

module tb_sqrt_engine;
    import sqrt_pkg::*;

    `include "sqrt_model.svh"

    localparam int CLK_HALF       = 4;
    localparam int INT_EDGE_COUNT = 11;
    localparam int FIX_EDGE_COUNT = 6;
    localparam int RANDOM_COUNT   = 200;
    localparam int OVERFLOW_COUNT = 20;
    localparam int RESET_FILL     = 6;
    localparam int BURST_COUNT    = 10;
    localparam int TOTAL_REQ      = INT_EDGE_COUNT + FIX_EDGE_COUNT + RANDOM_COUNT
                                    + OVERFLOW_COUNT + RESET_FILL + BURST_COUNT;
    localparam int TIMEOUT_CYCLES = TOTAL_REQ * 30 + 2000;

    logic                  clk;
    logic                  reset;
    logic                  req_push;
    sqrt_req_t             req;
    logic                  resp_valid;
    sqrt_resp_t            resp;
    logic                  full;
    logic                  empty;
    logic                  busy;
    logic [DROP_WIDTH-1:0] drop_count;

    // scoreboard.
    sqrt_resp_t            expect_q [$];
    logic [DATA_WIDTH-1:0] radicand_q [$];
    logic [DATA_WIDTH-1:0] int_edges [0:INT_EDGE_COUNT-1];
    logic [DATA_WIDTH-1:0] fix_edges [0:FIX_EDGE_COUNT-1];

    logic [31:0] rng_state;
    int          model_drops;
    int          err_count;
    int          check_count;
    int          tests_passed;
    int          tests_failed;
    int          errors_at_start;

    sqrt_engine dut0 (
        .clk        (clk),
        .reset      (reset),
        .req_push   (req_push),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp),
        .full       (full),
        .empty      (empty),
        .busy       (busy),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d responses still outstanding",
                 TIMEOUT_CYCLES, expect_q.size());
        $display("Some tests failed");
        $finish;
    end

    // **************************************************
    // response checking
    // **************************************************
    always @(negedge clk) begin : monitor
        sqrt_resp_t            exp_resp;
        logic [DATA_WIDTH-1:0] exp_rad;
        if (!reset && resp_valid) begin
            if (expect_q.size() == 0) begin
                $display("A response with tag %h arrived at %0t with no request outstanding",
                         resp.tag, $time);
                err_count++;
            end else begin
                exp_resp = expect_q.pop_front();
                exp_rad  = radicand_q.pop_front();
                check_count++;
                if (resp !== exp_resp) begin
                    $write("Fail at %0t: radicand %h mode %0d expected tag %h root %h",
                           $time, exp_rad, exp_resp.mode, exp_resp.tag, exp_resp.root);
                    $display(", got tag %h mode %0d root %h",
                             resp.tag, resp.mode, resp.root);
                    err_count++;
                end
            end
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // called 1 ns after a rising edge, returns at the same phase.
    task automatic drive_request(
        input logic [TAG_WIDTH-1:0]  tag,
        input sqrt_mode_e            mode,
        input logic [DATA_WIDTH-1:0] radicand
    );
        sqrt_resp_t exp_resp;
        exp_resp.tag  = tag;
        exp_resp.mode = mode;
        exp_resp.root = ref_root(mode == MODE_FIXED, radicand);
        req_push     = 1'b1;
        req.tag      = tag;
        req.mode     = mode;
        req.radicand = radicand;
        if (full) begin
            if (model_drops < 255) begin
                model_drops++;  // the queue drops it.
            end
        end else begin
            expect_q.push_back(exp_resp);
            radicand_q.push_back(radicand);
        end
        @(posedge clk);
        #1;
        req_push = 1'b0;
    endtask

    task automatic random_request();
        logic [31:0] r;
        logic [31:0] sel;
        r   = next_random();
        sel = next_random();
        drive_request(sel[7:4], sel[0] ? MODE_FIXED : MODE_INT, shape_radicand(r, sel[2:1]));
    endtask

    task automatic wait_for_room();
        while (full) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drained();
        while (expect_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        wait_drained();
        check_count++;
        if (drop_count !== DROP_WIDTH'(model_drops)) begin
            $display("Fail at %0t: drop_count %0d, expected %0d", $time, drop_count, model_drops);
            err_count++;
        end
        if (err_count == errors_at_start) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, err_count - errors_at_start);
        end
        errors_at_start = err_count;
    endtask

    // **************************************************
    // test sequence
    // **************************************************
    initial begin : main
        int i;
        rng_state       = 32'h61823f5c;
        reset           = 1'b1;
        req_push        = 1'b0;
        req             = '0;
        model_drops     = 0;
        err_count       = 0;
        check_count     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        int_edges = '{32'd0, 32'd1, 32'd2, 32'd3, 32'd4, 32'd15, 32'd16, 32'd65535,
                      32'd65536, 32'hfffe_0001, 32'hffff_ffff};
        fix_edges = '{32'h0000_0000, 32'h0000_0001, 32'h0001_0000, 32'h0002_0000,
                      32'h0000_4000, 32'hffff_ffff};
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        for (i = 0; i < INT_EDGE_COUNT; i++) begin
            drive_request(TAG_WIDTH'(i), MODE_INT, int_edges[i]);
            wait_drained();
        end
        finish_test(1, "integer edge values");

        check_count++;
        if (ref_root(1'b1, 32'h0001_0000) !== 32'h0001_0000 ||
            ref_root(1'b1, 32'h0000_4000) !== 32'h0000_8000) begin
            $display("The reference model gives wrong fixed roots for 1.0 or 0.25");
            err_count++;
        end
        for (i = 0; i < FIX_EDGE_COUNT; i++) begin
            drive_request(TAG_WIDTH'(i), MODE_FIXED, fix_edges[i]);
            wait_drained();
        end
        finish_test(2, "fixed edge values");

        for (i = 0; i < RANDOM_COUNT; i++) begin
            wait_for_room();
            random_request();
        end
        finish_test(3, "random traffic");

        // pushes ignore full here.
        for (i = 0; i < OVERFLOW_COUNT; i++) begin
            random_request();
        end
        check_count++;
        if (model_drops == 0) begin
            $display("The overflow burst never found the queue full, so nothing was dropped");
            err_count++;
        end
        finish_test(4, "overflow");

        // one in the core, the rest waiting.
        for (i = 0; i < RESET_FILL; i++) begin
            random_request();
        end
        repeat (5) @(posedge clk);
        #1;
        check_count++;
        if (busy !== 1'b1 || empty !== 1'b0) begin
            $display("Before reset the engine was not busy with more requests still queued");
            err_count++;
        end
        reset = 1'b1;
        expect_q.delete();
        radicand_q.delete();
        model_drops = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        check_count++;
        if (empty !== 1'b1 || full !== 1'b0 || drop_count !== '0 || busy !== 1'b0) begin
            $display("Fail at %0t: after reset empty %b full %b drop_count %0d busy %b",
                     $time, empty, full, drop_count, busy);
            err_count++;
        end
        repeat (40) @(posedge clk);  // any response here is stray.
        #1;
        for (i = 0; i < BURST_COUNT; i++) begin
            wait_for_room();
            random_request();
        end
        finish_test(5, "reset in flight");

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+dv
hw/sqrt_pkg.sv
hw/sqrt_req_fifo.sv
hw/fp_sqrt.sv
hw/sqrt_dispatch.sv
hw/sqrt_engine.sv
dv/tb_sqrt_engine.sv
